//--- logic/shaper_params.svh
// Shaper parameters
// Widths shared by the rate limiters, the frame arbiter and the top level

`ifndef SHAPER_PARAMS_SVH
`define SHAPER_PARAMS_SVH

// one byte per beat
`define SHAPER_DATA_WIDTH 8

// tuser is passed through untouched
`define SHAPER_USER_WIDTH 1

// pacing accumulator, wide enough for long frames at low rates
`define SHAPER_ACC_WIDTH 24

// rate_num and rate_denom
`define SHAPER_RATE_WIDTH 8

`endif

//--- logic/shaper_pkg.sv
// Shaper package
// Lane identifier carried with each merged output beat

package shaper_pkg;

    // source lane of a frame, driven on m_tid
    typedef enum logic [0:0] {
        LANE_A = 1'b0,
        LANE_B = 1'b1
    } lane_t;

endpackage

//--- logic/axis_rate_limit.sv
// AXI4-Stream rate limiter
// Paces one byte stream to rate_num/rate_denom of full throughput with an
// accumulator. In frame mode the pause waits for the end of the frame.
// Output goes through a registered skid stage so input ready can be registered.

`include "shaper_params.svh"

module axis_rate_limit #(
    parameter int DATA_WIDTH = `SHAPER_DATA_WIDTH,
    parameter int USER_WIDTH = `SHAPER_USER_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [DATA_WIDTH-1:0]         s_axis_tdata,
    input  logic                          s_axis_tvalid,
    output logic                          s_axis_tready,
    input  logic                          s_axis_tlast,
    input  logic [USER_WIDTH-1:0]         s_axis_tuser,

    output logic [DATA_WIDTH-1:0]         m_axis_tdata,
    output logic                          m_axis_tvalid,
    input  logic                          m_axis_tready,
    output logic                          m_axis_tlast,
    output logic [USER_WIDTH-1:0]         m_axis_tuser,

    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_num,
    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_denom,
    input  logic                          rate_by_frame
);

    localparam int ACC_WIDTH  = `SHAPER_ACC_WIDTH;
    localparam int RATE_WIDTH = `SHAPER_RATE_WIDTH;

    // pacing state
    logic [ACC_WIDTH-1:0]  acc_reg;
    logic [ACC_WIDTH-1:0]  acc_next;
    logic [ACC_WIDTH-1:0]  num_ext;
    logic [ACC_WIDTH-1:0]  step;
    logic                  frame_reg;
    logic                  frame_next;
    logic                  pause;
    logic                  s_ready_reg;
    logic                  s_ready_next;

    // beat handed to the skid stage
    logic [DATA_WIDTH-1:0] int_tdata;
    logic                  int_tvalid;
    logic                  int_tlast;
    logic [USER_WIDTH-1:0] int_tuser;
    logic                  ready_int_reg;
    logic                  ready_int_early;

    // skid stage registers
    logic [DATA_WIDTH-1:0] out_tdata_reg;
    logic                  out_tvalid_reg;
    logic                  out_tvalid_next;
    logic                  out_tlast_reg;
    logic [USER_WIDTH-1:0] out_tuser_reg;
    logic [DATA_WIDTH-1:0] tmp_tdata_reg;
    logic                  tmp_tvalid_reg;
    logic                  tmp_tvalid_next;
    logic                  tmp_tlast_reg;
    logic [USER_WIDTH-1:0] tmp_tuser_reg;
    logic                  store_int_to_out;
    logic                  store_int_to_tmp;
    logic                  store_tmp_to_out;

    assign num_ext = {{(ACC_WIDTH-RATE_WIDTH){1'b0}}, rate_num};
    // credit owed per accepted beat
    assign step    = {{(ACC_WIDTH-RATE_WIDTH){1'b0}}, rate_denom} - num_ext;

    assign s_axis_tready = s_ready_reg;

    assign int_tdata  = s_axis_tdata;
    assign int_tvalid = s_axis_tvalid && s_ready_reg;
    assign int_tlast  = s_axis_tlast;
    assign int_tuser  = s_axis_tuser;

    always_comb begin
        acc_next   = acc_reg;
        frame_next = frame_reg;
        pause      = 1'b0;

        // drain one num per cycle
        if (acc_reg >= num_ext) begin
            acc_next = acc_reg - num_ext;
        end

        if (int_tvalid) begin
            frame_next = !s_axis_tlast;
            acc_next   = acc_reg + step;
        end

        // in frame mode hold off the pause until the frame is done
        if (acc_next >= num_ext) begin
            pause = rate_by_frame ? !frame_next : 1'b1;
        end

        s_ready_next = ready_int_early && !pause;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_reg     <= '0;
            frame_reg   <= 1'b0;
            s_ready_reg <= 1'b0;
        end else begin
            acc_reg     <= acc_next;
            frame_reg   <= frame_next;
            s_ready_reg <= s_ready_next;
        end
    end

    // accept next cycle if downstream is ready or nothing is held
    assign ready_int_early = m_axis_tready || (!tmp_tvalid_reg && !out_tvalid_reg);

    always_comb begin
        out_tvalid_next  = out_tvalid_reg;
        tmp_tvalid_next  = tmp_tvalid_reg;
        store_int_to_out = 1'b0;
        store_int_to_tmp = 1'b0;
        store_tmp_to_out = 1'b0;

        if (ready_int_reg) begin
            if (m_axis_tready || !out_tvalid_reg) begin
                out_tvalid_next  = int_tvalid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_tvalid_next  = int_tvalid;
                store_int_to_tmp = 1'b1;
            end
        end else if (m_axis_tready) begin
            out_tvalid_next  = tmp_tvalid_reg;
            tmp_tvalid_next  = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid_reg <= 1'b0;
            tmp_tvalid_reg <= 1'b0;
            ready_int_reg  <= 1'b0;
        end else begin
            out_tvalid_reg <= out_tvalid_next;
            tmp_tvalid_reg <= tmp_tvalid_next;
            ready_int_reg  <= ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_tdata_reg <= int_tdata;
            out_tlast_reg <= int_tlast;
            out_tuser_reg <= int_tuser;
        end else if (store_tmp_to_out) begin
            out_tdata_reg <= tmp_tdata_reg;
            out_tlast_reg <= tmp_tlast_reg;
            out_tuser_reg <= tmp_tuser_reg;
        end

        if (store_int_to_tmp) begin
            tmp_tdata_reg <= int_tdata;
            tmp_tlast_reg <= int_tlast;
            tmp_tuser_reg <= int_tuser;
        end
    end

    assign m_axis_tdata  = out_tdata_reg;
    assign m_axis_tvalid = out_tvalid_reg;
    assign m_axis_tlast  = out_tlast_reg;
    assign m_axis_tuser  = out_tuser_reg;

endmodule

//--- logic/axis_frame_arbiter.sv
// Two-lane AXI4-Stream frame arbiter
// Round-robin grant held for a whole frame, output beats tagged with the
// source lane on m_tid. Registered skid output stage.

`include "shaper_params.svh"

module axis_frame_arbiter #(
    parameter int DATA_WIDTH = `SHAPER_DATA_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [DATA_WIDTH-1:0]         a_tdata,
    input  logic                          a_tvalid,
    output logic                          a_tready,
    input  logic                          a_tlast,
    input  logic [`SHAPER_USER_WIDTH-1:0] a_tuser,

    input  logic [DATA_WIDTH-1:0]         b_tdata,
    input  logic                          b_tvalid,
    output logic                          b_tready,
    input  logic                          b_tlast,
    input  logic [`SHAPER_USER_WIDTH-1:0] b_tuser,

    output logic [DATA_WIDTH-1:0]         m_tdata,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast,
    output logic [`SHAPER_USER_WIDTH-1:0] m_tuser,
    output shaper_pkg::lane_t             m_tid
);

    // grant_reg keeps the last served lane while idle
    shaper_pkg::lane_t grant_reg;
    shaper_pkg::lane_t grant_next;
    logic              busy_reg;
    logic              busy_next;

    logic [DATA_WIDTH-1:0]         sel_tdata;
    logic                          sel_tvalid;
    logic                          sel_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] sel_tuser;
    logic                          lane_ready;
    logic                          int_tvalid;
    logic                          ready_int_reg;
    logic                          ready_int_early;

    logic [DATA_WIDTH-1:0]         out_tdata_reg;
    logic                          out_tvalid_reg;
    logic                          out_tvalid_next;
    logic                          out_tlast_reg;
    logic [`SHAPER_USER_WIDTH-1:0] out_tuser_reg;
    shaper_pkg::lane_t             out_tid_reg;
    logic [DATA_WIDTH-1:0]         tmp_tdata_reg;
    logic                          tmp_tvalid_reg;
    logic                          tmp_tvalid_next;
    logic                          tmp_tlast_reg;
    logic [`SHAPER_USER_WIDTH-1:0] tmp_tuser_reg;
    shaper_pkg::lane_t             tmp_tid_reg;
    logic                          store_int_to_out;
    logic                          store_int_to_tmp;
    logic                          store_tmp_to_out;

    // granted lane mux
    assign sel_tdata  = (grant_reg == shaper_pkg::LANE_B) ? b_tdata  : a_tdata;
    assign sel_tvalid = (grant_reg == shaper_pkg::LANE_B) ? b_tvalid : a_tvalid;
    assign sel_tlast  = (grant_reg == shaper_pkg::LANE_B) ? b_tlast  : a_tlast;
    assign sel_tuser  = (grant_reg == shaper_pkg::LANE_B) ? b_tuser  : a_tuser;

    assign lane_ready = busy_reg && ready_int_reg;
    assign a_tready   = lane_ready && (grant_reg == shaper_pkg::LANE_A);
    assign b_tready   = lane_ready && (grant_reg == shaper_pkg::LANE_B);
    assign int_tvalid = lane_ready && sel_tvalid;

    always_comb begin
        grant_next = grant_reg;
        busy_next  = busy_reg;

        if (!busy_reg) begin
            // both waiting, switch away from the lane served last
            if (a_tvalid && b_tvalid) begin
                grant_next = (grant_reg == shaper_pkg::LANE_A) ?
                             shaper_pkg::LANE_B : shaper_pkg::LANE_A;
            end else if (a_tvalid) begin
                grant_next = shaper_pkg::LANE_A;
            end else if (b_tvalid) begin
                grant_next = shaper_pkg::LANE_B;
            end
            busy_next = a_tvalid || b_tvalid;
        end else if (int_tvalid && sel_tlast) begin
            busy_next = 1'b0;
        end
    end

    assign ready_int_early = m_tready || (!tmp_tvalid_reg && !out_tvalid_reg);

    always_comb begin
        out_tvalid_next  = out_tvalid_reg;
        tmp_tvalid_next  = tmp_tvalid_reg;
        store_int_to_out = 1'b0;
        store_int_to_tmp = 1'b0;
        store_tmp_to_out = 1'b0;

        if (ready_int_reg) begin
            if (m_tready || !out_tvalid_reg) begin
                out_tvalid_next  = int_tvalid;
                store_int_to_out = 1'b1;
            end else begin
                tmp_tvalid_next  = int_tvalid;
                store_int_to_tmp = 1'b1;
            end
        end else if (m_tready) begin
            out_tvalid_next  = tmp_tvalid_reg;
            tmp_tvalid_next  = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // lane A gets the first grant when both lanes are ready
            grant_reg      <= shaper_pkg::LANE_B;
            busy_reg       <= 1'b0;
            out_tvalid_reg <= 1'b0;
            tmp_tvalid_reg <= 1'b0;
            ready_int_reg  <= 1'b0;
        end else begin
            grant_reg      <= grant_next;
            busy_reg       <= busy_next;
            out_tvalid_reg <= out_tvalid_next;
            tmp_tvalid_reg <= tmp_tvalid_next;
            ready_int_reg  <= ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_tdata_reg <= sel_tdata;
            out_tlast_reg <= sel_tlast;
            out_tuser_reg <= sel_tuser;
            out_tid_reg   <= grant_reg;
        end else if (store_tmp_to_out) begin
            out_tdata_reg <= tmp_tdata_reg;
            out_tlast_reg <= tmp_tlast_reg;
            out_tuser_reg <= tmp_tuser_reg;
            out_tid_reg   <= tmp_tid_reg;
        end

        if (store_int_to_tmp) begin
            tmp_tdata_reg <= sel_tdata;
            tmp_tlast_reg <= sel_tlast;
            tmp_tuser_reg <= sel_tuser;
            tmp_tid_reg   <= grant_reg;
        end
    end

    assign m_tdata  = out_tdata_reg;
    assign m_tvalid = out_tvalid_reg;
    assign m_tlast  = out_tlast_reg;
    assign m_tuser  = out_tuser_reg;
    assign m_tid    = out_tid_reg;

endmodule

//--- logic/dual_rate_shaper.sv
// Dual-lane traffic shaper
// Two independent rate limiters merged frame by frame into one tagged stream

`include "shaper_params.svh"

module dual_rate_shaper (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`SHAPER_DATA_WIDTH-1:0] a_tdata,
    input  logic                          a_tvalid,
    output logic                          a_tready,
    input  logic                          a_tlast,
    input  logic [`SHAPER_USER_WIDTH-1:0] a_tuser,

    input  logic [`SHAPER_DATA_WIDTH-1:0] b_tdata,
    input  logic                          b_tvalid,
    output logic                          b_tready,
    input  logic                          b_tlast,
    input  logic [`SHAPER_USER_WIDTH-1:0] b_tuser,

    output logic [`SHAPER_DATA_WIDTH-1:0] m_tdata,
    output logic                          m_tvalid,
    input  logic                          m_tready,
    output logic                          m_tlast,
    output logic [`SHAPER_USER_WIDTH-1:0] m_tuser,
    output shaper_pkg::lane_t             m_tid,

    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_num_a,
    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_a,
    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_num_b,
    input  logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_b,
    input  logic                          rate_by_frame
);

    // paced lane A
    logic [`SHAPER_DATA_WIDTH-1:0] la_tdata;
    logic                          la_tvalid;
    logic                          la_tready;
    logic                          la_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] la_tuser;

    // paced lane B
    logic [`SHAPER_DATA_WIDTH-1:0] lb_tdata;
    logic                          lb_tvalid;
    logic                          lb_tready;
    logic                          lb_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] lb_tuser;

    axis_rate_limit limiter_a (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (a_tdata),
        .s_axis_tvalid (a_tvalid),
        .s_axis_tready (a_tready),
        .s_axis_tlast  (a_tlast),
        .s_axis_tuser  (a_tuser),
        .m_axis_tdata  (la_tdata),
        .m_axis_tvalid (la_tvalid),
        .m_axis_tready (la_tready),
        .m_axis_tlast  (la_tlast),
        .m_axis_tuser  (la_tuser),
        .rate_num      (rate_num_a),
        .rate_denom    (rate_denom_a),
        .rate_by_frame (rate_by_frame)
    );

    axis_rate_limit limiter_b (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (b_tdata),
        .s_axis_tvalid (b_tvalid),
        .s_axis_tready (b_tready),
        .s_axis_tlast  (b_tlast),
        .s_axis_tuser  (b_tuser),
        .m_axis_tdata  (lb_tdata),
        .m_axis_tvalid (lb_tvalid),
        .m_axis_tready (lb_tready),
        .m_axis_tlast  (lb_tlast),
        .m_axis_tuser  (lb_tuser),
        .rate_num      (rate_num_b),
        .rate_denom    (rate_denom_b),
        .rate_by_frame (rate_by_frame)
    );

    axis_frame_arbiter arbiter_i (
        .clk      (clk),
        .rst      (rst),
        .a_tdata  (la_tdata),
        .a_tvalid (la_tvalid),
        .a_tready (la_tready),
        .a_tlast  (la_tlast),
        .a_tuser  (la_tuser),
        .b_tdata  (lb_tdata),
        .b_tvalid (lb_tvalid),
        .b_tready (lb_tready),
        .b_tlast  (lb_tlast),
        .b_tuser  (lb_tuser),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tid    (m_tid)
    );

endmodule

//--- testbench/dual_rate_shaper_assert.sv
// Shaper port checker
// Bound to the top level. Watches reset, back-pressure, frame grouping,
// round-robin order, lane A pacing, tuser pass-through and per-lane byte order.

`include "shaper_params.svh"

module dual_rate_shaper_assert (
    input logic                          clk,
    input logic                          rst,
    input logic [`SHAPER_DATA_WIDTH-1:0] a_tdata,
    input logic                          a_tvalid,
    input logic                          a_tready,
    input logic                          a_tlast,
    input logic [`SHAPER_DATA_WIDTH-1:0] b_tdata,
    input logic                          b_tvalid,
    input logic                          b_tready,
    input logic [`SHAPER_DATA_WIDTH-1:0] m_tdata,
    input logic                          m_tvalid,
    input logic                          m_tready,
    input logic                          m_tlast,
    input logic [`SHAPER_USER_WIDTH-1:0] m_tuser,
    input shaper_pkg::lane_t             m_tid,
    input logic [`SHAPER_RATE_WIDTH-1:0] rate_num_a,
    input logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_a,
    input logic [`SHAPER_RATE_WIDTH-1:0] rate_num_b,
    input logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_b,
    input logic                          rate_by_frame
);

    localparam int FW = `SHAPER_DATA_WIDTH + `SHAPER_USER_WIDTH + 2;

    logic                          fail_seen;
    logic                          rst_q;
    logic                          a_hs;
    logic                          b_hs;
    logic                          m_hs;
    logic                          phase_fair;
    logic                          phase_paced;
    logic [FW-1:0]                 out_fields;
    logic [FW-1:0]                 held_fields;
    logic                          out_in_frame;
    logic                          have_frame;
    shaper_pkg::lane_t             frame_tid;
    shaper_pkg::lane_t             last_frame_tid;
    logic [7:0]                    a_gap;
    logic                          a_in_frame;
    logic                          a_seen;
    logic                          b_seen;
    logic [`SHAPER_DATA_WIDTH-1:0] exp_a;
    logic [`SHAPER_DATA_WIDTH-1:0] exp_b;

    initial fail_seen = 1'b0;

    assign a_hs        = a_tvalid && a_tready;
    assign b_hs        = b_tvalid && b_tready;
    assign m_hs        = m_tvalid && m_tready;
    // both lanes at full rate
    assign phase_fair  = (rate_num_a == rate_denom_a) && (rate_num_b == rate_denom_b) &&
                         !rate_by_frame;
    // lane A at one beat per denom cycles
    assign phase_paced = (rate_num_a == 8'd1) && (rate_denom_a > 8'd1);
    assign out_fields  = {m_tlast, m_tuser, m_tid, m_tdata};

    always_ff @(posedge clk) begin
        rst_q       <= rst;
        held_fields <= out_fields;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_in_frame   <= 1'b0;
            have_frame     <= 1'b0;
            frame_tid      <= shaper_pkg::LANE_A;
            last_frame_tid <= shaper_pkg::LANE_A;
            a_gap          <= 8'hff;
            a_in_frame     <= 1'b0;
            a_seen         <= 1'b0;
            b_seen         <= 1'b0;
            exp_a          <= '0;
            exp_b          <= '0;
        end else begin
            if (m_hs) begin
                out_in_frame <= !m_tlast;
                if (!out_in_frame) begin
                    frame_tid <= m_tid;
                end
                if (m_tlast) begin
                    last_frame_tid <= m_tid;
                    have_frame     <= 1'b1;
                end
            end
            // saturating count of cycles since the last lane A handshake
            if (a_hs) begin
                a_gap      <= 8'd1;
                a_in_frame <= !a_tlast;
            end else if (a_gap != 8'hff) begin
                a_gap <= a_gap + 1'b1;
            end
            // expected bytes start from the first byte each lane accepts
            if (a_hs && !a_seen) begin
                a_seen <= 1'b1;
                exp_a  <= a_tdata;
            end else if (m_hs && m_tid == shaper_pkg::LANE_A) begin
                exp_a <= exp_a + 1'b1;
            end
            if (b_hs && !b_seen) begin
                b_seen <= 1'b1;
                exp_b  <= b_tdata;
            end else if (m_hs && m_tid == shaper_pkg::LANE_B) begin
                exp_b <= exp_b + 1'b1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) rst_q |-> !m_tvalid && !a_tready && !b_tready)
        else begin
            fail_seen = 1'b1;
            $error("** Error reset_quiet: expected valid/ready 000, actual %b%b%b",
                   $sampled(m_tvalid), $sampled(a_tready), $sampled(b_tready));
        end

    hold_valid: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid)
        else begin
            fail_seen = 1'b1;
            $error("** Error hold_valid: expected m_tvalid 1, actual %b", $sampled(m_tvalid));
        end

    hold_fields: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> out_fields == held_fields)
        else begin
            fail_seen = 1'b1;
            $error("** Error hold_fields: expected %0h, actual %0h",
                   $sampled(held_fields), $sampled(out_fields));
        end

    frame_lane: assert property (@(posedge clk) disable iff (rst)
        m_hs && out_in_frame |-> m_tid == frame_tid)
        else begin
            fail_seen = 1'b1;
            $error("** Error frame_lane: expected lane %0d, actual lane %0d",
                   $sampled(frame_tid), $sampled(m_tid));
        end

    round_robin: assert property (@(posedge clk) disable iff (rst)
        m_hs && !out_in_frame && have_frame && phase_fair |-> m_tid != last_frame_tid)
        else begin
            fail_seen = 1'b1;
            $error("** Error round_robin: expected lane %0d, actual lane %0d",
                   !$sampled(last_frame_tid), $sampled(m_tid));
        end

    pace_gap: assert property (@(posedge clk) disable iff (rst)
        a_hs && phase_paced && !rate_by_frame |-> a_gap >= rate_denom_a)
        else begin
            fail_seen = 1'b1;
            $error("** Error pace_gap: expected gap >= %0d, actual %0d",
                   $sampled(rate_denom_a), $sampled(a_gap));
        end

    // no pacing pause inside a frame in frame mode
    frame_no_pause: assert property (@(posedge clk) disable iff (rst)
        a_hs && phase_paced && rate_by_frame && a_in_frame |-> a_gap < rate_denom_a)
        else begin
            fail_seen = 1'b1;
            $error("** Error frame_no_pause: expected gap < %0d, actual %0d",
                   $sampled(rate_denom_a), $sampled(a_gap));
        end

    // tuser is sent as the low bits of each byte
    user_pass: assert property (@(posedge clk) disable iff (rst)
        m_hs |-> m_tuser == m_tdata[`SHAPER_USER_WIDTH-1:0])
        else begin
            fail_seen = 1'b1;
            $error("** Error user_pass: expected tuser %0h, actual %0h",
                   $sampled(m_tdata[`SHAPER_USER_WIDTH-1:0]), $sampled(m_tuser));
        end

    order_a: assert property (@(posedge clk) disable iff (rst)
        m_hs && m_tid == shaper_pkg::LANE_A |-> m_tdata == exp_a)
        else begin
            fail_seen = 1'b1;
            $error("** Error order_a: expected %0h, actual %0h",
                   $sampled(exp_a), $sampled(m_tdata));
        end

    order_b: assert property (@(posedge clk) disable iff (rst)
        m_hs && m_tid == shaper_pkg::LANE_B |-> m_tdata == exp_b)
        else begin
            fail_seen = 1'b1;
            $error("** Error order_b: expected %0h, actual %0h",
                   $sampled(exp_b), $sampled(m_tdata));
        end

endmodule

bind dual_rate_shaper dual_rate_shaper_assert checks_i (.*);

//--- testbench/dual_rate_shaper_tb.sv
// Testbench for the dual-lane traffic shaper
// Random frames on both lanes at full rate, then lane A paced per beat
// and per frame. Checking is done by the bound assertion module.

`include "shaper_params.svh"

module dual_rate_shaper_tb;

    localparam int WAIT_LIMIT  = 400;
    localparam int FAIR_FRAMES = 12;

    logic                          clk;
    logic                          rst;
    logic [`SHAPER_DATA_WIDTH-1:0] a_tdata;
    logic                          a_tvalid;
    logic                          a_tready;
    logic                          a_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] a_tuser;
    logic [`SHAPER_DATA_WIDTH-1:0] b_tdata;
    logic                          b_tvalid;
    logic                          b_tready;
    logic                          b_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] b_tuser;
    logic [`SHAPER_DATA_WIDTH-1:0] m_tdata;
    logic                          m_tvalid;
    logic                          m_tready;
    logic                          m_tlast;
    logic [`SHAPER_USER_WIDTH-1:0] m_tuser;
    shaper_pkg::lane_t             m_tid;
    logic [`SHAPER_RATE_WIDTH-1:0] rate_num_a;
    logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_a;
    logic [`SHAPER_RATE_WIDTH-1:0] rate_num_b;
    logic [`SHAPER_RATE_WIDTH-1:0] rate_denom_b;
    logic                          rate_by_frame;

    // next byte per lane, counting up
    logic [`SHAPER_DATA_WIDTH-1:0] a_byte;
    logic [`SHAPER_DATA_WIDTH-1:0] b_byte;
    logic [31:0]                   rnd;
    int                            sent_count;
    int                            out_count;
    logic                          ready_random;
    int                            stall_left;

    dual_rate_shaper dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after a failure");
    endtask

    // tuser carries the low bits of the byte
    task automatic send_frame(input bit lane_b, input int len);
        int   beat;
        int   waited;
        logic rdy;
        for (beat = 0; beat < len; beat++) begin
            if (lane_b) begin
                b_tdata  <= b_byte;
                b_tvalid <= 1'b1;
                b_tlast  <= (beat == len - 1);
                b_tuser  <= b_byte[`SHAPER_USER_WIDTH-1:0];
                b_byte    = b_byte + 1'b1;
            end else begin
                a_tdata  <= a_byte;
                a_tvalid <= 1'b1;
                a_tlast  <= (beat == len - 1);
                a_tuser  <= a_byte[`SHAPER_USER_WIDTH-1:0];
                a_byte    = a_byte + 1'b1;
            end
            waited = 0;
            rdy    = 1'b0;
            while (!rdy) begin
                @(posedge clk);
                rdy = lane_b ? b_tready : a_tready;
                waited++;
                if (!rdy && waited >= WAIT_LIMIT) begin
                    report_failure("timeout: input lane never accepted a beat");
                end
            end
            sent_count++;
        end
    endtask

    // back-to-back frames of 1 to 6 beats with valid dropped after the last
    task automatic send_frames(input bit lane_b, input int frames);
        int n;
        int len;
        for (n = 0; n < frames; n++) begin
            len = 1 + int'($urandom % 6);
            send_frame(lane_b, len);
        end
        if (lane_b) begin
            b_tvalid <= 1'b0;
        end else begin
            a_tvalid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count != sent_count) begin
            @(posedge clk);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                report_failure("timeout: output did not deliver every beat sent");
            end
        end
    endtask

    // random output stalls of 1 to 3 cycles
    always @(posedge clk) begin
        if (!ready_random) begin
            m_tready <= 1'b1;
        end else if (stall_left > 0) begin
            m_tready   <= 1'b0;
            stall_left <= stall_left - 1;
        end else if ($urandom % 5 == 0) begin
            m_tready   <= 1'b0;
            stall_left <= $urandom % 3;
        end else begin
            m_tready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && m_tvalid && m_tready) begin
            out_count <= out_count + 1;
        end
    end

    always @(posedge clk) begin
        if (dut_i.checks_i.fail_seen) begin
            report_failure("an assertion check failed");
        end
    end

    initial begin
        void'($urandom(99655));
        rst           = 1'b1;
        a_tdata       = '0;
        a_tvalid      = 1'b0;
        a_tlast       = 1'b0;
        a_tuser       = '0;
        b_tdata       = '0;
        b_tvalid      = 1'b0;
        b_tlast       = 1'b0;
        b_tuser       = '0;
        m_tready      = 1'b0;
        rate_num_a    = 8'd4;
        rate_denom_a  = 8'd4;
        rate_num_b    = 8'd4;
        rate_denom_b  = 8'd4;
        rate_by_frame = 1'b0;
        ready_random  = 1'b0;
        stall_left    = 0;
        sent_count    = 0;
        out_count     = 0;
        rnd           = $urandom;
        a_byte        = rnd[`SHAPER_DATA_WIDTH-1:0];
        rnd           = $urandom;
        b_byte        = rnd[`SHAPER_DATA_WIDTH-1:0];

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // both lanes at full rate with random output stalls
        ready_random <= 1'b1;
        fork
            send_frames(1'b0, FAIR_FRAMES);
            send_frames(1'b1, FAIR_FRAMES);
        join
        ready_random <= 1'b0;
        wait_drain();
        repeat (8) @(posedge clk);

        // lane A at a quarter rate paced per beat
        rate_num_a   <= 8'd1;
        rate_denom_a <= 8'd4;
        repeat (4) @(posedge clk);
        send_frames(1'b0, 4);
        wait_drain();
        repeat (8) @(posedge clk);

        // same rate paced per frame
        rate_by_frame <= 1'b1;
        repeat (4) @(posedge clk);
        send_frame(1'b0, 5);
        a_tvalid <= 1'b0;
        wait_drain();
        repeat (8) @(posedge clk);

        if (dut_i.checks_i.fail_seen) begin
            report_failure("an assertion check failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+logic
logic/shaper_pkg.sv
logic/axis_rate_limit.sv
logic/axis_frame_arbiter.sv
logic/dual_rate_shaper.sv
testbench/dual_rate_shaper_assert.sv
testbench/dual_rate_shaper_tb.sv

//--- Bender.yml
package:
  name: dual_rate_shaper

sources:
  - include_dirs:
      - logic
    files:
      - logic/shaper_pkg.sv
      - logic/axis_rate_limit.sv
      - logic/axis_frame_arbiter.sv
      - logic/dual_rate_shaper.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/dual_rate_shaper_assert.sv
      - testbench/dual_rate_shaper_tb.sv
